//--- Bender.yml
package:
  name: pcie_arbiter

sources:
  - src/irqPkg.sv
  - src/irqConfRegs.sv
  - src/irqReqFifo.sv
  - src/irqRingWriter.sv
  - src/pcieArbiter.sv
  - target: test
    files:
      - tests/pcieArbiterAsserts_asserts.sv
      - tests/pcieArbiterTb.sv

//--- build.f
src/irqPkg.sv
src/irqConfRegs.sv
src/irqReqFifo.sv
src/irqRingWriter.sv
src/pcieArbiter.sv
tests/pcieArbiterAsserts_asserts.sv
tests/pcieArbiterTb.sv

//--- src/irqConfRegs.sv
module irqConfRegs (
   input  logic               clock,
   input  logic               reset,
   input  irqPkg::confBus_t   confBus_i,
   input  irqPkg::dropCount_t dropCount_i,
   output irqPkg::busWord_t   confReadData_o,
   output irqPkg::hostAddr_t  ringBase_o,
   output logic               ringRestart_o
);

   irqPkg::busWord_t baseHigh;
   irqPkg::busWord_t baseLow;
   logic confWrite;
   logic confRead;
   logic highWrite;
   logic lowWrite;

   assign confWrite = confBus_i.chipSelect & confBus_i.write;
   assign confRead = confBus_i.chipSelect & confBus_i.read;

   assign highWrite = confWrite && (confBus_i.address == irqPkg::BaseHighAddr);
   assign lowWrite = confWrite && (confBus_i.address == irqPkg::BaseLowAddr);

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         baseHigh <= '0;
         baseLow <= '0;
      end else begin
         if (highWrite) begin
            baseHigh <= confBus_i.writeData;
         end
         if (lowWrite) begin
            baseLow <= confBus_i.writeData;
         end
      end
   end

   assign ringBase_o = {baseHigh, baseLow};

   // Offset restarts at the same edge the new low half lands
   assign ringRestart_o = lowWrite;

   // Read data is valid in the cycle of the read
   always_comb begin
      confReadData_o = '0;
      if (confRead) begin
         case (confBus_i.address)
            irqPkg::BaseHighAddr: begin
               confReadData_o = baseHigh;
            end
            irqPkg::BaseLowAddr: begin
               confReadData_o = baseLow;
            end
            irqPkg::DropCountAddr: begin
               confReadData_o = irqPkg::busWord_t'(dropCount_i);
            end
            default: begin
               confReadData_o = '0;
            end
         endcase
      end
   end

endmodule

//--- src/irqPkg.sv
package irqPkg;

   typedef logic [63:0] hostAddr_t;
   typedef logic [31:0] busWord_t;
   typedef logic [7:0] confAddr_t;
   typedef logic [55:0] reqInfo_t;
   typedef logic [15:0] dropCount_t;
   // Ring of 32 words, 16 records
   typedef logic [4:0] ringOffset_t;

   localparam int FifoDepth = 8;
   localparam int FifoPtrWidth = $clog2(FifoDepth);

   typedef logic [FifoPtrWidth-1:0] fifoPtr_t;
   typedef logic [FifoPtrWidth:0] fifoCount_t;

   localparam confAddr_t BaseHighAddr = 8'h10;
   localparam confAddr_t BaseLowAddr = 8'h14;
   localparam confAddr_t DropCountAddr = 8'h18;

   typedef struct packed {
      logic chipSelect;
      logic write;
      logic read;
      confAddr_t address;
      busWord_t writeData;
   } confBus_t;

   typedef struct packed {
      logic write;
      hostAddr_t address;
      busWord_t writeData;
   } memReq_t;

   typedef enum logic [1:0] {Idle, HighWord, LowWord} writerState_t;

endpackage

//--- src/irqReqFifo.sv
module irqReqFifo (
   input  logic               clock,
   input  logic               reset,
   input  logic               push_i,
   input  irqPkg::reqInfo_t   pushData_i,
   input  logic               pop_i,
   output irqPkg::reqInfo_t   head_o,
   output logic               empty_o,
   output irqPkg::dropCount_t dropCount_o
);

   irqPkg::reqInfo_t entries [irqPkg::FifoDepth];
   irqPkg::fifoPtr_t wrPtr;
   irqPkg::fifoPtr_t rdPtr;
   irqPkg::fifoCount_t count;
   irqPkg::dropCount_t dropCount;
   logic full;
   logic doPush;
   logic doPop;

   assign full = (count == irqPkg::fifoCount_t'(irqPkg::FifoDepth));
   assign empty_o = (count == '0);
   assign doPush = push_i & ~full;
   assign doPop = pop_i & ~empty_o;

   always_ff @(posedge clock) begin
      if (doPush) begin
         entries[wrPtr] <= pushData_i;
      end
   end

   // Depth is a power of two, pointers wrap by themselves
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (doPop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         if (doPush && !doPop) begin
            count <= count + 1'b1;
         end else if (doPop && !doPush) begin
            count <= count - 1'b1;
         end
      end
   end

   // Lost requests, saturating
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         dropCount <= '0;
      end else if (push_i && full && (dropCount != '1)) begin
         dropCount <= dropCount + 1'b1;
      end
   end

   assign head_o = entries[rdPtr];
   assign dropCount_o = dropCount;

endmodule

//--- src/irqRingWriter.sv
module irqRingWriter (
   input  logic              clock,
   input  logic              reset,
   input  irqPkg::reqInfo_t  head_i,
   input  logic              empty_i,
   input  irqPkg::hostAddr_t ringBase_i,
   input  logic              ringRestart_i,
   input  logic              memWaitRequest_i,
   output logic              pop_o,
   output irqPkg::memReq_t   memReq_o
);

   irqPkg::writerState_t state;
   irqPkg::writerState_t nextState;
   irqPkg::writerState_t beat;
   irqPkg::ringOffset_t ringOffset;
   logic accepted;

   // A waiting record starts its high word straight from Idle,
   // so it goes out the cycle after it was queued
   always_comb begin
      beat = state;
      if (state == irqPkg::Idle && !empty_i) begin
         beat = irqPkg::HighWord;
      end
   end

   assign accepted = memReq_o.write & ~memWaitRequest_i;

   always_comb begin
      nextState = beat;
      if (accepted) begin
         case (beat)
            irqPkg::HighWord: begin
               nextState = irqPkg::LowWord;
            end
            // Back in Idle the next record, if any, is already on the bus
            irqPkg::LowWord: begin
               nextState = irqPkg::Idle;
            end
            default: begin
               nextState = irqPkg::Idle;
            end
         endcase
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= irqPkg::Idle;
      end else begin
         state <= nextState;
      end
   end

   // One ring word per accepted beat
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         ringOffset <= '0;
      end else if (ringRestart_i) begin
         ringOffset <= '0;
      end else if (accepted) begin
         ringOffset <= ringOffset + 1'b1;
      end
   end

   always_comb begin
      memReq_o.write = (beat != irqPkg::Idle);
      memReq_o.address = ringBase_i + irqPkg::hostAddr_t'({ringOffset, 2'b00});
      if (beat == irqPkg::HighWord) begin
         memReq_o.writeData = {8'h00, head_i[55:32]};
      end else begin
         memReq_o.writeData = head_i[31:0];
      end
   end

   // Record leaves the FIFO once its low word is taken
   assign pop_o = accepted && (beat == irqPkg::LowWord);

endmodule

//--- src/pcieArbiter.sv
module pcieArbiter (
   input  logic              clock,
   input  logic              reset,
   input  irqPkg::confBus_t  confBus_i,
   output irqPkg::busWord_t  confReadData_o,
   input  logic              reqValid_i,
   input  irqPkg::reqInfo_t  reqInfo_i,
   input  logic              memWaitRequest_i,
   output irqPkg::memReq_t   memReq_o
);

   irqPkg::dropCount_t dropCount;
   irqPkg::hostAddr_t ringBase;
   logic ringRestart;
   irqPkg::reqInfo_t fifoHead;
   logic fifoEmpty;
   logic fifoPop;

   irqConfRegs i_confRegs (
      .clock          (clock),
      .reset          (reset),
      .confBus_i      (confBus_i),
      .dropCount_i    (dropCount),
      .confReadData_o (confReadData_o),
      .ringBase_o     (ringBase),
      .ringRestart_o  (ringRestart)
   );

   // Request strobe has no back-pressure, overflow is counted here
   irqReqFifo i_reqFifo (
      .clock       (clock),
      .reset       (reset),
      .push_i      (reqValid_i),
      .pushData_i  (reqInfo_i),
      .pop_i       (fifoPop),
      .head_o      (fifoHead),
      .empty_o     (fifoEmpty),
      .dropCount_o (dropCount)
   );

   irqRingWriter i_ringWriter (
      .clock            (clock),
      .reset            (reset),
      .head_i           (fifoHead),
      .empty_i          (fifoEmpty),
      .ringBase_i       (ringBase),
      .ringRestart_i    (ringRestart),
      .memWaitRequest_i (memWaitRequest_i),
      .pop_o            (fifoPop),
      .memReq_o         (memReq_o)
   );

endmodule

//--- tests/pcieArbiterAsserts_asserts.sv
module pcieArbiterAsserts (
   input logic            clock,
   input logic            reset,
   input irqPkg::memReq_t memReq_i,
   input logic            memWaitRequest_i,
   input logic            pop_i
);

   timeunit 1ns;
   timeprecision 100ps;

   logic secondBeat;

   // Beats pair up into records, every second one completes a record
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         secondBeat <= 1'b0;
      end else if (memReq_i.write && !memWaitRequest_i) begin
         secondBeat <= ~secondBeat;
      end
   end

   // Stalled beat holds address and data
   assert property (@(posedge clock) disable iff (!reset)
      (memReq_i.write && memWaitRequest_i) |=>
         (memReq_i.write && $stable(memReq_i.address) && $stable(memReq_i.writeData)))
      else $error("memory beat changed while waitrequest was high");

   assert property (@(posedge clock) !reset |-> !memReq_i.write)
      else $error("memory write high during reset");

   // Pop belongs to an accepted low word
   assert property (@(posedge clock) disable iff (!reset)
      pop_i == (memReq_i.write && !memWaitRequest_i && secondBeat))
      else $error("FIFO pop not matched to an accepted low word");

endmodule

bind pcieArbiter pcieArbiterAsserts i_asserts (
   .clock            (clock),
   .reset            (reset),
   .memReq_i         (memReq_o),
   .memWaitRequest_i (memWaitRequest_i),
   .pop_i            (fifoPop)
);

//--- tests/pcieArbiterTb.sv
module pcieArbiterTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ResetCycles = 10;
   localparam int TotalRecords = 1 + 6 + 20 + 1 + 12;
   // Up to about 8 cycles per record under random waitrequest, plus register
   // accesses and settle waits, with a wide margin
   localparam int TimeoutCycles = 10 * (ResetCycles + 8 * TotalRecords + 100);
   localparam int NoWait = 0;
   localparam int RandomWait = 1;
   localparam int HoldWait = 2;

   logic clock;
   logic reset;
   irqPkg::confBus_t confBus;
   irqPkg::busWord_t confReadData;
   logic reqValid;
   irqPkg::reqInfo_t reqInfo;
   logic memWaitRequest = 1'b0;
   irqPkg::memReq_t memReq;

   integer seed = 14;
   int waitMode = NoWait;
   int cycleCount = 0;
   irqPkg::memReq_t beats[$];
   irqPkg::reqInfo_t expInfo[$];
   irqPkg::hostAddr_t expBase = '0;
   int expOffset = 0;

   pcieArbiter i_dut (
      .clock            (clock),
      .reset            (reset),
      .confBus_i        (confBus),
      .confReadData_o   (confReadData),
      .reqValid_i       (reqValid),
      .reqInfo_i        (reqInfo),
      .memWaitRequest_i (memWaitRequest),
      .memReq_o         (memReq)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // Memory side: waitrequest source and beat recorder
   always @(posedge clock) begin
      if (waitMode == HoldWait) begin
         memWaitRequest <= 1'b1;
      end else if (waitMode == RandomWait) begin
         memWaitRequest <= (($random(seed) & 32'h3) == 0);
      end else begin
         memWaitRequest <= 1'b0;
      end
   end

   always @(negedge clock) begin
      if (reset && memReq.write && !memWaitRequest) begin
         beats.push_back(memReq);
      end
   end

   initial begin
      while (cycleCount < TimeoutCycles) begin
         @(posedge clock);
         cycleCount++;
      end
      $display("timeout: the DUT did not finish the tests within %0d cycles", TimeoutCycles);
      $display(">>> FAIL");
      $fatal(1, "run stopped by timeout");
   end

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      if (actual !== expected) begin
         $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display(">>> FAIL");
         $fatal(1, "run stopped at first error");
      end
   endtask

   function automatic irqPkg::hostAddr_t expAddress();
      return expBase + irqPkg::hostAddr_t'(4 * expOffset);
   endfunction

   task automatic writeReg(input irqPkg::confAddr_t addr, input irqPkg::busWord_t data);
      @(posedge clock);
      confBus <= {1'b1, 1'b1, 1'b0, addr, data};
      if (addr == irqPkg::BaseHighAddr) begin
         expBase[63:32] = data;
      end else if (addr == irqPkg::BaseLowAddr) begin
         expBase[31:0] = data;
         expOffset = 0;
      end
      @(posedge clock);
      confBus <= '0;
   endtask

   task automatic readReg(input irqPkg::confAddr_t addr, input irqPkg::busWord_t expected);
      @(posedge clock);
      confBus <= {1'b1, 1'b0, 1'b1, addr, 32'h0};
      @(negedge clock);
      checkValue("confReadData_o", confReadData, expected);
      @(posedge clock);
      confBus <= '0;
   endtask

   // Strobes on consecutive cycles
   task automatic pushBurst(input int count);
      irqPkg::reqInfo_t info;
      for (int i = 0; i < count; i++) begin
         info = irqPkg::reqInfo_t'({$random(seed), $random(seed)});
         @(posedge clock);
         reqValid <= 1'b1;
         reqInfo <= info;
         expInfo.push_back(info);
      end
      @(posedge clock);
      reqValid <= 1'b0;
   endtask

   task automatic waitForBeats(input int count);
      while (beats.size() < count) begin
         @(negedge clock);
      end
   endtask

   task automatic checkRecords(input int count);
      irqPkg::reqInfo_t info;
      irqPkg::memReq_t beat;
      for (int i = 0; i < count; i++) begin
         info = expInfo.pop_front();
         beat = beats.pop_front();
         checkValue("memReq_o.address", beat.address, expAddress());
         checkValue("memReq_o.writeData", beat.writeData, {8'h00, info[55:32]});
         expOffset = (expOffset + 1) % 32;
         beat = beats.pop_front();
         checkValue("memReq_o.address", beat.address, expAddress());
         checkValue("memReq_o.writeData", beat.writeData, info[31:0]);
         expOffset = (expOffset + 1) % 32;
      end
   endtask

   task automatic testRegisterAccess();
      // Low half close to the top so the address sum carries
      writeReg(irqPkg::BaseHighAddr, 32'h0000_0001);
      writeReg(irqPkg::BaseLowAddr, 32'hFFFF_FFF0);
      readReg(irqPkg::BaseHighAddr, 32'h0000_0001);
      readReg(irqPkg::BaseLowAddr, 32'hFFFF_FFF0);
      readReg(irqPkg::DropCountAddr, 32'h0);
      readReg(8'h1C, 32'h0);
   endtask

   task automatic testSingleRecord();
      waitMode = NoWait;
      pushBurst(1);
      waitForBeats(2);
      repeat (8) @(negedge clock);
      checkValue("beatCount", beats.size(), 2);
      checkRecords(1);
   endtask

   task automatic testOrderedStream();
      waitMode = RandomWait;
      pushBurst(6);
      waitForBeats(12);
      checkRecords(6);
   endtask

   task automatic testRingWrap();
      writeReg(irqPkg::BaseLowAddr, 32'h0000_8000);
      // Groups of four stay within the FIFO, beat 33 lands back on the base
      for (int g = 0; g < 5; g++) begin
         pushBurst(4);
         waitForBeats(8);
         checkRecords(4);
      end
      writeReg(irqPkg::BaseLowAddr, 32'h0004_0000);
      pushBurst(1);
      waitForBeats(2);
      checkRecords(1);
   endtask

   task automatic testOverflow();
      int completed;
      int fit;
      waitMode = HoldWait;
      @(posedge clock);
      pushBurst(12);
      // A record frees its slot only after its low word is taken
      completed = beats.size() / 2;
      fit = irqPkg::FifoDepth + completed;
      if (fit > 12) begin
         fit = 12;
      end
      waitMode = RandomWait;
      waitForBeats(2 * fit);
      repeat (10) @(negedge clock);
      checkValue("beatCount", beats.size(), 2 * fit);
      checkRecords(fit);
      expInfo.delete();
      readReg(irqPkg::DropCountAddr, irqPkg::busWord_t'(12 - fit));
   endtask

   initial begin
      reset = 1'b0;
      confBus = '0;
      reqValid = 1'b0;
      reqInfo = '0;
      repeat (ResetCycles) @(posedge clock);
      reset <= 1'b1;
      @(posedge clock);
      testRegisterAccess();
      testSingleRecord();
      testOrderedStream();
      testRingWrap();
      testOverflow();
      $display(">>> PASS");
      $finish;
   end

endmodule
